// ==== compile.f ====
rtl/rfPkg.sv
rtl/rfArray.sv
rtl/obsCompress.sv
rtl/bistAddrCounter.sv
rtl/bistSequencer.sv
rtl/bistChecker.sv
rtl/phaseRegFile.sv
tests/phaseRegFileTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= phaseRegFileTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/phaseRegFileTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module phaseRegFileTb;

  typedef logic [rfPkg::dataWidth-1:0] dataWord;
  typedef logic [rfPkg::addrWidth-1:0] addrWord;

  localparam int obsGroup = 3;
  localparam int obsFlopCount = (rfPkg::obsPinCount + obsGroup - 1) / obsGroup;

  // test lengths in clock cycles give the watchdog limit
  localparam int resetCycles = 4;
  localparam int funcOps = 200;
  localparam int scanOps = 8;
  localparam int obsOps = 100;
  localparam int bistCycles = 385;
  localparam int bistLimit = bistCycles + 16;
  localparam int marginCycles = 500;
  localparam int watchdogCycles = resetCycles + rfPkg::depth + 3 * funcOps + 2 * scanOps
                                  + obsOps + 2 * (bistCycles + 8) + rfPkg::depth
                                  + marginCycles;

  logic clock;
  logic rstN;
  rfPkg::rfWrite writePort;
  rfPkg::rfRead readPort;
  logic scanMode;
  logic bistStart;
  dataWord readData;
  rfPkg::bistStatus bistStat;
  logic [obsFlopCount-1:0] obsOut;

  // model of the array contents as the functional ports should leave them
  dataWord refMem [rfPkg::depth];
  logic [31:0] lcgState = 32'd18;

  phaseRegFile #(
    .obsXorSize (obsGroup)
  ) phaseRegFile_i (
    .clock     (clock),
    .rstN      (rstN),
    .writePort (writePort),
    .readPort  (readPort),
    .scanMode  (scanMode),
    .bistStart (bistStart),
    .readData  (readData),
    .bistStat  (bistStat),
    .obsOut    (obsOut)
  );

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial
  begin
    repeat (watchdogCycles) @(posedge clock);
    reportFailure("watchdog expired before all tests finished");
  end

  // ----------------------------------------
  // random numbers and reference models
  // ----------------------------------------

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // the upper bits of the generator are the better ones
  function automatic addrWord randomAddr();
    logic [31:0] r;
    r = lcgNext();
    return r[29:24];
  endfunction

  function automatic logic randomBit();
    logic [31:0] r;
    r = lcgNext();
    return r[30];
  endfunction

  function automatic dataWord randomData();
    logic [95:0] bits;
    bits = {lcgNext(), lcgNext(), lcgNext()};
    return bits[rfPkg::dataWidth-1:0];
  endfunction

  // parity per group of observed lines where the top group takes the leftover bits
  function automatic logic [obsFlopCount-1:0] groupParity(
    input logic [rfPkg::obsPinCount-1:0] lines
  );
    logic [obsFlopCount-1:0] p;
    p = '0;
    for (int b = 0; b < rfPkg::obsPinCount; b++)
    begin
      p[b / obsGroup] = p[b / obsGroup] ^ lines[b];
    end
    return p;
  endfunction

  function automatic rfPkg::bistStatus expectedStatus(input logic busy, input logic done,
                                                      input logic pass, input addrWord failAddr);
    rfPkg::bistStatus s;
    s.busy = busy;
    s.done = done;
    s.pass = pass;
    s.failAddr = failAddr;
    return s;
  endfunction

  // ----------------------------------------
  // checks
  // ----------------------------------------

  task automatic reportFailure(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic checkData(input string name, input dataWord got, input dataWord exp);
    if (got !== exp)
    begin
      reportFailure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkStatus(input string name, input rfPkg::bistStatus got,
                             input rfPkg::bistStatus exp);
    if (got !== exp)
    begin
      reportFailure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkObs(input string name, input logic [obsFlopCount-1:0] got,
                          input logic [obsFlopCount-1:0] exp);
    if (got !== exp)
    begin
      reportFailure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic checkAfterReset();
    checkData("readData", readData, '0);
    checkStatus("bistStat", bistStat, expectedStatus(1'b0, 1'b0, 1'b0, '0));
  endtask

  task automatic runFunctional();
    addrWord addr;
    dataWord data;
    dataWord expected;
    // every entry gets a known value first since the array has no reset
    for (int a = 0; a < rfPkg::depth; a++)
    begin
      data = randomData();
      writePort.en = 1'b1;
      writePort.addr = addrWord'(a);
      writePort.data = data;
      refMem[a] = data;
      @(posedge clock);
      #1;
    end
    writePort.en = 1'b0;
    for (int i = 0; i < funcOps; i++)
    begin
      addr = randomAddr();
      data = randomData();
      if (randomBit())
      begin
        writePort.en = 1'b1;
        writePort.addr = addr;
        writePort.data = data;
        @(posedge clock);
        #1;
        writePort.en = 1'b0;
        refMem[addr] = data;
      end
      else
      begin
        readPort.en = 1'b1;
        readPort.addr = addr;
        @(posedge clock);
        #1;
        readPort.en = 1'b0;
        expected = refMem[addr];
        checkData("readData", readData, expected);
        // without read en the register keeps its value even when the entry changes
        writePort.en = 1'b1;
        writePort.addr = addr;
        writePort.data = data;
        @(posedge clock);
        #1;
        writePort.en = 1'b0;
        refMem[addr] = data;
        // one more idle cycle puts the new entry in front of the read register
        @(posedge clock);
        #1;
        checkData("readData", readData, expected);
      end
    end
  endtask

  task automatic runScan();
    addrWord addr;
    dataWord data;
    for (int i = 0; i < scanOps; i++)
    begin
      addr = randomAddr();
      data = randomData();
      // the read points at a different entry so only the bus can supply data
      scanMode = 1'b1;
      writePort.en = 1'b1;
      writePort.addr = addr;
      writePort.data = data;
      readPort.en = 1'b1;
      readPort.addr = addr ^ addrWord'(1);
      @(posedge clock);
      #1;
      scanMode = 1'b0;
      writePort.en = 1'b0;
      refMem[addr] = data;
      checkData("readData", readData, data);
      readPort.addr = addr;
      @(posedge clock);
      #1;
      readPort.en = 1'b0;
      checkData("readData", readData, refMem[addr]);
    end
  endtask

  task automatic runObservation();
    logic [rfPkg::obsPinCount-1:0] lines;
    lines = '0;
    for (int i = 0; i <= obsOps; i++)
    begin
      if (i < obsOps)
      begin
        writePort.en = randomBit();
        writePort.addr = randomAddr();
        writePort.data = randomData();
        readPort.en = randomBit();
        readPort.addr = randomAddr();
      end
      else
      begin
        writePort.en = 1'b0;
        readPort.en = 1'b0;
      end
      if (i > 0)
      begin
        // the lines have already moved on and only the flops still hold the last sample
        #2;
        checkObs("obsOut", obsOut, groupParity(lines));
      end
      // write addr sits at bit 0, then write en, read addr and read en
      lines = {readPort.en, readPort.addr, writePort.en, writePort.addr};
      if (writePort.en)
      begin
        refMem[writePort.addr] = writePort.data;
      end
      @(posedge clock);
      #1;
    end
  endtask

  task automatic runBist(input logic scan, input logic expectPass, input addrWord expectAddr);
    int cycles;
    logic seenDone;
    scanMode = scan;
    bistStart = 1'b1;
    @(posedge clock);
    #1;
    bistStart = 1'b0;
    // a new run clears pass and the recorded fail address
    checkStatus("bistStat", bistStat, expectedStatus(1'b1, 1'b0, 1'b0, '0));
    cycles = 0;
    seenDone = 1'b0;
    while (!seenDone && (cycles < bistLimit))
    begin
      // functional traffic while busy must never reach the array
      writePort.en = 1'b1;
      writePort.addr = randomAddr();
      writePort.data = randomData();
      readPort.en = 1'b1;
      readPort.addr = randomAddr();
      @(posedge clock);
      #1;
      cycles++;
      seenDone = bistStat.done;
      if (!seenDone)
      begin
        checkStatus("bistStat", bistStat, expectedStatus(1'b1, 1'b0, 1'b0, expectAddr));
      end
    end
    writePort.en = 1'b0;
    readPort.en = 1'b0;
    if (!seenDone)
    begin
      reportFailure("BIST done never pulsed after start");
    end
    if (cycles != bistCycles)
    begin
      reportFailure($sformatf("BIST done came %0d cycles after start instead of %0d",
                              cycles, bistCycles));
    end
    checkStatus("bistStat", bistStat, expectedStatus(1'b0, 1'b1, expectPass, expectAddr));
    @(posedge clock);
    #1;
    scanMode = 1'b0;
    // done drops after one cycle while the result stays
    checkStatus("bistStat", bistStat, expectedStatus(1'b0, 1'b0, expectPass, expectAddr));
  endtask

  task automatic readBackAll();
    for (int a = 0; a < rfPkg::depth; a++)
    begin
      readPort.en = 1'b1;
      readPort.addr = addrWord'(a);
      @(posedge clock);
      #1;
      checkData("readData", readData, refMem[a]);
    end
    readPort.en = 1'b0;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial
  begin
    rstN = 1'b0;
    writePort = '0;
    readPort = '0;
    scanMode = 1'b0;
    bistStart = 1'b0;
    repeat (resetCycles) @(posedge clock);
    #1;
    rstN = 1'b1;
    checkAfterReset();
    runFunctional();
    runScan();
    runObservation();
    runBist(1'b0, 1'b1, '0);
    // the last march element reads zeros, so the run leaves an all-zero array
    for (int a = 0; a < rfPkg::depth; a++)
    begin
      refMem[a] = '0;
    end
    readBackAll();
    // write-through hands ones to the first read of the second element at address 0
    runBist(1'b1, 1'b0, '0);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/phaseRegFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module phaseRegFile
#(
  parameter int obsXorSize = 3,
  localparam int obsFlopCount = (rfPkg::obsPinCount + obsXorSize - 1) / obsXorSize
)
(
  input  logic clock,
  input  logic rstN,
  input  rfPkg::rfWrite writePort,
  input  rfPkg::rfRead readPort,
  input  logic scanMode,
  input  logic bistStart,
  output logic [rfPkg::dataWidth-1:0] readData,
  output rfPkg::bistStatus bistStat,
  output logic [obsFlopCount-1:0] obsOut
);

  rfPkg::rfWrite seqWr;
  rfPkg::rfWrite arrWr;
  rfPkg::rfRead seqRd;
  rfPkg::rfRead arrRd;
  rfPkg::bistStatus seqStat;
  logic [rfPkg::obsPinCount-1:0] obsVec;
  logic [rfPkg::addrWidth-1:0] cntAddr;
  logic cntLast;
  logic cntLoad;
  logic cntDown;
  logic cntStep;
  logic expectBit;
  logic checkClear;
  logic chkFail;
  logic [rfPkg::addrWidth-1:0] chkFailAddr;

  // ----------------------------------------
  // port mux and observation
  // ----------------------------------------

  // the self-test owns the array for the whole run
  assign arrWr = seqStat.busy ? seqWr : writePort;
  assign arrRd = seqStat.busy ? seqRd : readPort;

  // bit 0 upward is write addr, write en, read addr, read en
  assign obsVec = {arrRd.en, arrRd.addr, arrWr.en, arrWr.addr};

  assign bistStat = '{busy: seqStat.busy, done: seqStat.done, pass: seqStat.pass,
                      failAddr: chkFailAddr};

  rfArray array_i (
    .clock    (clock),
    .rstN     (rstN),
    .wr       (arrWr),
    .rd       (arrRd),
    .scanMode (scanMode),
    .readData (readData)
  );

  obsCompress #(
    .pinCount (rfPkg::obsPinCount),
    .xorSize  (obsXorSize)
  ) obs_i (
    .clock  (clock),
    .obsIn  (obsVec),
    .obsOut (obsOut)
  );

  // ----------------------------------------
  // self-test
  // ----------------------------------------

  bistAddrCounter counter_i (
    .clock (clock),
    .rstN  (rstN),
    .load  (cntLoad),
    .down  (cntDown),
    .step  (cntStep),
    .addr  (cntAddr),
    .last  (cntLast)
  );

  bistSequencer sequencer_i (
    .clock      (clock),
    .rstN       (rstN),
    .start      (bistStart),
    .addr       (cntAddr),
    .last       (cntLast),
    .cntLoad    (cntLoad),
    .cntDown    (cntDown),
    .cntStep    (cntStep),
    .wr         (seqWr),
    .rd         (seqRd),
    .expectBit  (expectBit),
    .checkClear (checkClear),
    .fail       (chkFail),
    .stat       (seqStat)
  );

  bistChecker checker_i (
    .clock     (clock),
    .rstN      (rstN),
    .clear     (checkClear),
    .readEn    (seqRd.en),
    .expectBit (expectBit),
    .addr      (cntAddr),
    .readData  (readData),
    .fail      (chkFail),
    .failAddr  (chkFailAddr)
  );

endmodule

`default_nettype wire

// ==== rtl/bistChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module bistChecker
(
  input  logic clock,
  input  logic rstN,
  input  logic clear,
  input  logic readEn,
  input  logic expectBit,
  input  logic [rfPkg::addrWidth-1:0] addr,
  input  logic [rfPkg::dataWidth-1:0] readData,
  output logic fail,
  output logic [rfPkg::addrWidth-1:0] failAddr
);

  // read request delayed by one cycle to meet the registered read data
  logic readEnD;
  logic expectD;
  logic [rfPkg::addrWidth-1:0] addrD;
  logic failFlag;
  logic mismatch;

  assign mismatch = readEnD && (readData != {rfPkg::dataWidth{expectD}});

  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      readEnD <= 1'b0;
      expectD <= 1'b0;
      addrD <= '0;
      failFlag <= 1'b0;
      failAddr <= '0;
    end
    else if (clear)
    begin
      readEnD <= 1'b0;
      expectD <= 1'b0;
      addrD <= '0;
      failFlag <= 1'b0;
      failAddr <= '0;
    end
    else
    begin
      readEnD <= readEn;
      expectD <= expectBit;
      addrD <= addr;
      // only the first mismatch is recorded
      if (mismatch && !failFlag)
      begin
        failFlag <= 1'b1;
        failAddr <= addrD;
      end
    end
  end

  // the compare of the current cycle is included so the last read of a run
  // is seen on the same edge that ends it
  assign fail = failFlag || mismatch;

endmodule

`default_nettype wire

// ==== rtl/bistSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module bistSequencer
(
  input  logic clock,
  input  logic rstN,
  input  logic start,
  input  logic [rfPkg::addrWidth-1:0] addr,
  input  logic last,
  output logic cntLoad,
  output logic cntDown,
  output logic cntStep,
  output rfPkg::rfWrite wr,
  output rfPkg::rfRead rd,
  output logic expectBit,
  output logic checkClear,
  input  logic fail,
  output rfPkg::bistStatus stat
);

  rfPkg::marchElem state;
  rfPkg::marchElem nextState;

  // in the read-write elements phase 0 is the read, phase 1 the write
  logic phase;
  logic doneReg;
  logic passReg;
  logic idleStart;

  // start is only taken from idle
  assign idleStart = start && (state == rfPkg::elemIdle);
  assign checkClear = idleStart;

  // the only load into a descending element happens when leaving r0w1
  assign cntDown = (state == rfPkg::elemR0W1Up);

  // ----------------------------------------
  // element decode
  // ----------------------------------------

  always_comb
  begin
    nextState = state;
    cntLoad = 1'b0;
    cntStep = 1'b0;
    expectBit = 1'b0;
    wr = '0;
    rd = '0;
    wr.addr = addr;
    rd.addr = addr;
    case (state)
      rfPkg::elemIdle:
      begin
        if (start)
        begin
          nextState = rfPkg::elemInitW0;
          cntLoad = 1'b1;
        end
      end
      rfPkg::elemInitW0:
      begin
        // one zero write per cycle, ascending
        wr.en = 1'b1;
        cntStep = 1'b1;
        if (last)
        begin
          nextState = rfPkg::elemR0W1Up;
          cntLoad = 1'b1;
        end
      end
      rfPkg::elemR0W1Up:
      begin
        // the data bus carries ones through both phases, which is what
        // scan write-through hands back on the read
        wr.data = '1;
        rd.en = !phase;
        wr.en = phase;
        if (phase)
        begin
          cntStep = 1'b1;
          if (last)
          begin
            nextState = rfPkg::elemR1W0Down;
            cntLoad = 1'b1;
          end
        end
      end
      rfPkg::elemR1W0Down:
      begin
        expectBit = 1'b1;
        rd.en = !phase;
        wr.en = phase;
        if (phase)
        begin
          cntStep = 1'b1;
          if (last)
          begin
            nextState = rfPkg::elemR0Up;
            cntLoad = 1'b1;
          end
        end
      end
      rfPkg::elemR0Up:
      begin
        // final read-only pass over an array that is left all zero
        rd.en = 1'b1;
        cntStep = 1'b1;
        if (last)
        begin
          nextState = rfPkg::elemFinish;
        end
      end
      rfPkg::elemFinish:
      begin
        // drain cycle for the compare of the last read
        nextState = rfPkg::elemIdle;
      end
      default:
      begin
        nextState = rfPkg::elemIdle;
      end
    endcase
  end

  // ----------------------------------------
  // state and status registers
  // ----------------------------------------

  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= rfPkg::elemIdle;
      phase <= 1'b0;
      doneReg <= 1'b0;
      passReg <= 1'b0;
    end
    else
    begin
      state <= nextState;
      // done pulses on the cycle after the drain, together with busy falling
      doneReg <= (state == rfPkg::elemFinish);
      if (idleStart)
      begin
        phase <= 1'b0;
      end
      else if ((state == rfPkg::elemR0W1Up) || (state == rfPkg::elemR1W0Down))
      begin
        phase <= !phase;
      end
      // pass holds its result until the next run starts
      if (idleStart)
      begin
        passReg <= 1'b0;
      end
      else if (state == rfPkg::elemFinish)
      begin
        passReg <= !fail;
      end
    end
  end

  // failAddr comes from the checker and is merged in the top level
  assign stat = '{busy: (state != rfPkg::elemIdle), done: doneReg, pass: passReg,
                  failAddr: '0};

endmodule

`default_nettype wire

// ==== rtl/bistAddrCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bistAddrCounter
(
  input  logic clock,
  input  logic rstN,
  input  logic load,
  input  logic down,
  input  logic step,
  output logic [rfPkg::addrWidth-1:0] addr,
  output logic last
);

  localparam logic [rfPkg::addrWidth-1:0] lastAddr = (rfPkg::addrWidth)'(rfPkg::depth - 1);

  // direction is taken at load and kept for the whole march element,
  // so down only has to be valid on the load cycle
  logic dirDown;

  // load wins over step, the sequencer raises both on the final address
  // of an element
  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      addr <= '0;
      dirDown <= 1'b0;
    end
    else if (load)
    begin
      addr <= down ? lastAddr : '0;
      dirDown <= down;
    end
    else if (step)
    begin
      if (dirDown)
      begin
        addr <= addr - 1'b1;
      end
      else
      begin
        addr <= addr + 1'b1;
      end
    end
  end

  // last marks the final address in the current direction
  assign last = dirDown ? (addr == '0) : (addr == lastAddr);

endmodule

`default_nettype wire

// ==== rtl/obsCompress.sv ====
`timescale 1ns/100ps
`default_nettype none

module obsCompress
#(
  parameter int pinCount = 1,
  parameter int xorSize = 3,
  // one flop per full group plus one for a partial group at the top
  localparam int flopCount = (pinCount + xorSize - 1) / xorSize
)
(
  input  logic clock,
  input  logic [pinCount-1:0] obsIn,
  output logic [flopCount-1:0] obsOut
);

  logic [flopCount-1:0] groupParity;
  logic [flopCount-1:0] obsFlops;

  // group g covers bits g*xorSize upward, the last group takes what is left
  for (genvar g = 0; g < flopCount; g++)
  begin : groupXor
    if (g < flopCount - 1)
    begin : fullGroup
      assign groupParity[g] = ^obsIn[g*xorSize +: xorSize];
    end
    else
    begin : tailGroup
      assign groupParity[g] = ^obsIn[pinCount-1:g*xorSize];
    end
  end

  // one observation flop per group on the scan chain
  always_ff @(posedge clock)
  begin
    obsFlops <= groupParity;
  end

  assign obsOut = obsFlops;

endmodule

`default_nettype wire

// ==== rtl/rfArray.sv ====
`timescale 1ns/100ps
`default_nettype none

module rfArray
(
  input  logic clock,
  input  logic rstN,
  input  rfPkg::rfWrite wr,
  input  rfPkg::rfRead rd,
  input  logic scanMode,
  output logic [rfPkg::dataWidth-1:0] readData
);

  // ----------------------------------------
  // storage
  // ----------------------------------------

  // plain flop array with one write port
  logic [rfPkg::dataWidth-1:0] mem [rfPkg::depth];

  always_ff @(posedge clock)
  begin
    if (wr.en)
    begin
      mem[wr.addr] <= wr.data;
    end
  end

  // ----------------------------------------
  // read register
  // ----------------------------------------

  // the read register only moves when read en is high, otherwise the
  // last value stays on readData
  // in scan mode the register captures the write data bus of the same
  // cycle so the scan chain sees the data path without the array
  // a read and a write to the same entry in one cycle return the old entry
  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      readData <= '0;
    end
    else if (rd.en)
    begin
      if (scanMode)
      begin
        readData <= wr.data;
      end
      else
      begin
        readData <= mem[rd.addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rfPkg.sv ====
`default_nettype none

package rfPkg;

  // ----------------------------------------
  // array geometry
  // ----------------------------------------

  localparam int addrWidth = 6;
  localparam int dataWidth = 66;
  localparam int depth = 64;

  // observed lines are write addr, write en, read addr and read en
  localparam int obsPinCount = 2 * addrWidth + 2;

  // ----------------------------------------
  // port bundles
  // ----------------------------------------

  // the array ignores write data while en is low
  typedef struct packed {
    logic en;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] data;
  } rfWrite;

  typedef struct packed {
    logic en;
    logic [addrWidth-1:0] addr;
  } rfRead;

  // self-test status as seen from outside the array
  typedef struct packed {
    logic busy;
    logic done;
    logic pass;
    logic [addrWidth-1:0] failAddr;
  } bistStatus;

  // march elements, in the order the sequencer walks them
  typedef enum logic [2:0] {
    elemIdle,
    elemInitW0,
    elemR0W1Up,
    elemR1W0Down,
    elemR0Up,
    elemFinish
  } marchElem;

endpackage

`default_nettype wire
